// File: fpga_board_glue.f
hdl/board_pkg.sv
hdl/board_rst_sync.sv
hdl/rtc_divider.sv
hdl/fan_pwm.sv
hdl/board_cfg_regs.sv
hdl/board_top.sv
dv/board_top_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the board glue testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/10ps \
  --top-module board_top_tb \
  -Mdir obj_dir \
  -f fpga_board_glue.f

./obj_dir/Vboard_top_tb > sim.log 2>&1
cat sim.log

if grep -qx "sim passed" sim.log; then
  echo "run_sim: testbench reported success"
  exit 0
else
  echo "run_sim: testbench reported failure"
  exit 1
fi

// File: dv/board_top_tb.sv
/*
 * Testbench for the board glue top level
 * Reset release, RTC period, register bus handshake, boot mode
 * selection and fan PWM duty, driven from a stimulus table
 */

`timescale 1ns/10ps

module board_top_tb;

  localparam int AckTimeout = 50;

  typedef struct packed {
    logic        we;
    logic [7:0]  addr;
    logic [31:0] wdata;
    logic [3:0]  fan_sw;
    logic [31:0] exp_rdata;
    logic        exp_err;
    int          exp_boot;   // -1 means boot_mode_o follows the pins
    int          exp_level;  // -1 means no duty check
  } step_t;

  logic        soc_clk;
  logic        rst_n;
  logic        test_mode_i;
  logic [1:0]  boot_mode_i;
  logic [3:0]  fan_sw_i;
  logic        reg_req_i;
  logic        reg_we_i;
  logic [7:0]  reg_addr_i;
  logic [31:0] reg_wdata_i;
  logic        reg_ack_o;
  logic [31:0] reg_rdata_o;
  logic        reg_err_o;
  logic [1:0]  boot_mode_o;
  logic        rtc_o;
  logic        fan_pwm_o;
  logic        soc_rst_no;

  int          errors;
  int          timeouts;
  logic [31:0] rng_state;
  step_t       steps[$];

  board_top UUT (.*);

  initial begin
    soc_clk = 1'b0;
    forever #10 soc_clk = ~soc_clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic log_mismatch(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic add_step(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                          input logic [3:0] fan_sw, input logic [31:0] exp_rdata,
                          input logic exp_err, input int exp_boot, input int exp_level);
    step_t s;
    s = '{we, addr, wdata, fan_sw, exp_rdata, exp_err, exp_boot, exp_level};
    steps.push_back(s);
  endtask

  // Control outputs while the board reset is asserted
  task automatic check_idle(input string phase);
    assert (reg_ack_o == 1'b0) else log_mismatch({"reg_ack_o high ", phase});
    assert (reg_err_o == 1'b0) else log_mismatch({"reg_err_o high ", phase});
    assert (rtc_o == 1'b0) else log_mismatch({"rtc_o high ", phase});
    assert (fan_pwm_o == 1'b0) else log_mismatch({"fan_pwm_o high ", phase});
    assert (soc_rst_no == 1'b0) else log_mismatch({"soc_rst_no high ", phase});
  endtask

  ////////////////////
  // Register bus
  ////////////////////

  task automatic bus_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int cyc;
    assert (reg_ack_o == 1'b0) else log_mismatch("reg_ack_o high before request");
    reg_we_i    = we;
    reg_addr_i  = addr;
    reg_wdata_i = wdata;
    reg_req_i   = 1'b1;
    cyc = 0;
    while (reg_ack_o !== 1'b1 && cyc < AckTimeout) begin
      @(posedge soc_clk);
      #2;
      cyc++;
    end
    if (reg_ack_o !== 1'b1) begin
      $display("The register slave never raised reg_ack_o for address %h", addr);
      timeouts++;
    end else begin
      assert (cyc == 1) else log_mismatch($sformatf("ack after %0d cycles, expected 1", cyc));
    end
    rdata = reg_rdata_o;
    err   = reg_err_o;
    // Req held one extra cycle with the response frozen
    @(posedge soc_clk);
    #2;
    assert (reg_ack_o == 1'b1) else log_mismatch("reg_ack_o dropped while req still high");
    assert (reg_rdata_o == rdata) else log_mismatch("reg_rdata_o changed during ack");
    reg_req_i = 1'b0;
    cyc = 0;
    while (reg_ack_o !== 1'b0 && cyc < AckTimeout) begin
      @(posedge soc_clk);
      #2;
      cyc++;
    end
    if (reg_ack_o !== 1'b0) begin
      $display("The register slave kept reg_ack_o high after the request was dropped");
      timeouts++;
    end else begin
      assert (cyc == 1) else log_mismatch($sformatf("ack fell after %0d cycles", cyc));
    end
  endtask

  task automatic reg_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rdata;
    bus_access(1'b1, addr, data, unused_rdata, err);
  endtask

  task automatic reg_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    bus_access(1'b0, addr, 32'h0, data, err);
  endtask

  // Two full PWM periods once the new level has been latched
  task automatic check_fan_duty(input int level);
    int high_cnt;
    int exp_high;
    int window;
    window   = 2 * int'(board_pkg::FanSteps) * int'(board_pkg::FanStepCycles);
    exp_high = 2 * level * int'(board_pkg::FanStepCycles);
    high_cnt = 0;
    repeat (window) @(posedge soc_clk);
    repeat (window) begin
      @(posedge soc_clk);
      #2;
      if (fan_pwm_o) high_cnt++;
    end
    assert (high_cnt == exp_high)
      else log_mismatch($sformatf("fan level %0d gave %0d high cycles, expected %0d",
                                  level, high_cnt, exp_high));
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    logic [31:0] rdata;
    logic        err;
    logic [1:0]  pins;
    logic [1:0]  exp_boot;
    logic        last_rtc;
    logic        stalled;
    int          cyc;
    int          since;
    int          toggles;

    errors      = 0;
    timeouts    = 0;
    rng_state   = 32'd14033;
    rst_n       = 1'b0;
    test_mode_i = 1'b0;
    boot_mode_i = 2'b00;
    fan_sw_i    = 4'h0;
    reg_req_i   = 1'b0;
    reg_we_i    = 1'b0;
    reg_addr_i  = 8'h00;
    reg_wdata_i = 32'h0;

    // we addr wdata fan_sw exp_rdata exp_err exp_boot exp_level
    add_step(1'b0, 8'h08, 32'h0000_0000, 4'd0, 32'h0C4E_5A01, 1'b0, -1, -1);
    add_step(1'b0, 8'h0C, 32'h0000_0000, 4'd0, 32'hBADC_AB1E, 1'b1, -1, -1);
    add_step(1'b0, 8'h80, 32'h0000_0000, 4'd0, 32'hBADC_AB1E, 1'b1, -1, -1);
    add_step(1'b1, 8'h10, 32'hFFFF_FFFF, 4'd0, 32'h0000_0000, 1'b1, -1, -1);
    add_step(1'b1, 8'h08, 32'h0000_0000, 4'd0, 32'h0000_0000, 1'b0, -1, -1);
    add_step(1'b0, 8'h00, 32'h0000_0000, 4'd0, 32'h0000_0000, 1'b0, -1, -1);
    add_step(1'b0, 8'h04, 32'h0000_0000, 4'd0, 32'h0000_0000, 1'b0, -1, -1);
    add_step(1'b0, 8'h08, 32'h0000_0000, 4'd0, 32'h0C4E_5A01, 1'b0, -1, 0);
    add_step(1'b0, 8'h08, 32'h0000_0000, 4'd5, 32'h0C4E_5A01, 1'b0, -1, 5);
    add_step(1'b0, 8'h08, 32'h0000_0000, 4'd15, 32'h0C4E_5A01, 1'b0, -1, 15);
    add_step(1'b1, 8'h00, 32'hFFFF_FFF6, 4'd0, 32'h0000_0000, 1'b0, 2, -1);
    add_step(1'b0, 8'h00, 32'h0000_0000, 4'd0, 32'h0000_0006, 1'b0, 2, -1);
    add_step(1'b1, 8'h00, 32'h0000_0005, 4'd0, 32'h0000_0000, 1'b0, 1, -1);
    add_step(1'b0, 8'h00, 32'h0000_0000, 4'd0, 32'h0000_0005, 1'b0, 1, -1);
    add_step(1'b1, 8'h04, 32'h0000_0010, 4'd15, 32'h0000_0000, 1'b0, 1, 0);
    add_step(1'b1, 8'h04, 32'h0000_0015, 4'd0, 32'h0000_0000, 1'b0, 1, 5);
    add_step(1'b1, 8'h04, 32'h0000_001F, 4'd3, 32'h0000_0000, 1'b0, 1, 15);
    add_step(1'b0, 8'h04, 32'h0000_0000, 4'd3, 32'h0000_001F, 1'b0, 1, -1);
    add_step(1'b1, 8'hFC, 32'h0000_0000, 4'd3, 32'h0000_0000, 1'b1, 1, -1);
    add_step(1'b0, 8'h00, 32'h0000_0000, 4'd3, 32'h0000_0005, 1'b0, 1, -1);
    add_step(1'b0, 8'h04, 32'h0000_0000, 4'd3, 32'h0000_001F, 1'b0, 1, -1);
    add_step(1'b1, 8'h00, 32'h0000_0003, 4'd3, 32'h0000_0000, 1'b0, -1, -1);
    add_step(1'b0, 8'h00, 32'h0000_0000, 4'd3, 32'h0000_0003, 1'b0, -1, -1);

    repeat (10) begin
      @(posedge soc_clk);
      #2;
      check_idle("during reset");
    end
    rst_n = 1'b1;

    // SoC reset release and RTC toggles over four periods
    cyc      = 0;
    since    = 0;
    toggles  = 0;
    last_rtc = 1'b0;
    stalled  = 1'b0;
    while (toggles < 8 && !stalled) begin
      @(posedge soc_clk);
      #2;
      cyc++;
      since++;
      if (cyc == 1) check_idle("right after reset release");
      if (cyc == 2) begin
        assert (soc_rst_no == 1'b1) else log_mismatch("soc_rst_no not released");
      end
      if (rtc_o != last_rtc) begin
        assert (since == int'(board_pkg::RtcHalfPeriod))
          else log_mismatch($sformatf("rtc_o toggled after %0d cycles", since));
        since    = 0;
        last_rtc = rtc_o;
        toggles++;
      end else if (since > 2 * int'(board_pkg::RtcHalfPeriod)) begin
        $display("rtc_o stopped toggling after reset release");
        timeouts++;
        stalled = 1'b1;
      end
    end

    foreach (steps[i]) begin
      @(posedge soc_clk);
      #2;
      rng_state   = xorshift32(rng_state);
      pins        = rng_state[1:0];
      boot_mode_i = pins;
      fan_sw_i    = steps[i].fan_sw;
      if (steps[i].we) begin
        reg_write(steps[i].addr, steps[i].wdata, err);
      end else begin
        reg_read(steps[i].addr, rdata, err);
        assert (rdata == steps[i].exp_rdata)
          else log_mismatch($sformatf("step %0d read %h, expected %h", i, rdata,
                                      steps[i].exp_rdata));
      end
      assert (err == steps[i].exp_err)
        else log_mismatch($sformatf("step %0d err %b, expected %b", i, err, steps[i].exp_err));
      exp_boot = (steps[i].exp_boot < 0) ? pins : 2'(steps[i].exp_boot);
      assert (boot_mode_o == exp_boot)
        else log_mismatch($sformatf("step %0d boot_mode_o %0d, expected %0d", i, boot_mode_o,
                                    exp_boot));
      if (steps[i].exp_level >= 0) check_fan_duty(steps[i].exp_level);
    end

    // Scan bypass lets soc_rst_no follow rst_n without the chain
    @(posedge soc_clk);
    #2;
    test_mode_i = 1'b1;
    rst_n       = 1'b0;
    #1;
    check_idle("after rst_n fell in test mode");
    repeat (3) @(posedge soc_clk);
    #2;
    rst_n = 1'b1;
    #1;
    assert (soc_rst_no == 1'b1) else log_mismatch("soc_rst_no did not follow rst_n in test mode");
    @(posedge soc_clk);
    #2;
    test_mode_i = 1'b0;

    $display("Checks done: %0d value errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: hdl/board_top.sv
/*
 * FPGA board glue top level
 * SoC reset release, RTC tick, fan PWM and boot mode selection
 * behind a small configuration register bus
 */

`timescale 1ns/10ps

module board_top (
  input  logic                                soc_clk,
  input  logic                                rst_n,
  input  logic                                test_mode_i,
  input  logic [board_pkg::BootModeWidth-1:0] boot_mode_i,
  input  logic [board_pkg::FanLevelWidth-1:0] fan_sw_i,
  input  logic                                reg_req_i,
  input  logic                                reg_we_i,
  input  logic [board_pkg::RegAddrWidth-1:0]  reg_addr_i,
  input  logic [board_pkg::RegDataWidth-1:0]  reg_wdata_i,
  output logic                                reg_ack_o,
  output logic [board_pkg::RegDataWidth-1:0]  reg_rdata_o,
  output logic                                reg_err_o,
  output logic [board_pkg::BootModeWidth-1:0] boot_mode_o,
  output logic                                rtc_o,
  output logic                                fan_pwm_o,
  output logic                                soc_rst_no
);

  // Effective fan level after the override mux
  logic [board_pkg::FanLevelWidth-1:0] fan_level;

  board_rst_sync i_rst_sync (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .test_mode_i ( test_mode_i ),
    .soc_rst_no  ( soc_rst_no  )
  );

  rtc_divider i_rtc_divider (
    .soc_clk ( soc_clk ),
    .rst_n   ( rst_n   ),
    .rtc_o   ( rtc_o   )
  );

  // Register state runs on the board reset, not the synchronized one
  board_cfg_regs i_cfg_regs (
    .soc_clk     ( soc_clk     ),
    .rst_n       ( rst_n       ),
    .reg_req_i   ( reg_req_i   ),
    .reg_we_i    ( reg_we_i    ),
    .reg_addr_i  ( reg_addr_i  ),
    .reg_wdata_i ( reg_wdata_i ),
    .reg_ack_o   ( reg_ack_o   ),
    .reg_rdata_o ( reg_rdata_o ),
    .reg_err_o   ( reg_err_o   ),
    .boot_mode_i ( boot_mode_i ),
    .fan_sw_i    ( fan_sw_i    ),
    .boot_mode_o ( boot_mode_o ),
    .fan_level_o ( fan_level   )
  );

  fan_pwm i_fan_pwm (
    .soc_clk     ( soc_clk   ),
    .rst_n       ( rst_n     ),
    .fan_level_i ( fan_level ),
    .fan_pwm_o   ( fan_pwm_o )
  );

endmodule

// File: hdl/board_cfg_regs.sv
/*
 * Board configuration register slave
 * Four-phase req/ack bus with boot and fan override registers,
 * a read-only ID and an error word for unmapped addresses
 */

`timescale 1ns/10ps

module board_cfg_regs (
  input  logic                                soc_clk,
  input  logic                                rst_n,
  input  logic                                reg_req_i,
  input  logic                                reg_we_i,
  input  logic [board_pkg::RegAddrWidth-1:0]  reg_addr_i,
  input  logic [board_pkg::RegDataWidth-1:0]  reg_wdata_i,
  output logic                                reg_ack_o,
  output logic [board_pkg::RegDataWidth-1:0]  reg_rdata_o,
  output logic                                reg_err_o,
  input  logic [board_pkg::BootModeWidth-1:0] boot_mode_i,
  input  logic [board_pkg::FanLevelWidth-1:0] fan_sw_i,
  output logic [board_pkg::BootModeWidth-1:0] boot_mode_o,
  output logic [board_pkg::FanLevelWidth-1:0] fan_level_o
);

  logic                                ack_q;
  logic                                err_q;
  logic [board_pkg::RegDataWidth-1:0]  rdata_q;
  logic [board_pkg::BootSelBit:0]      boot_ovr_q;
  logic [board_pkg::FanEnBit:0]        fan_ovr_q;
  logic                                access;
  logic                                sel_boot;
  logic                                sel_fan;
  logic [board_pkg::RegDataWidth-1:0]  rdata_d;
  logic                                err_d;

  ////////////////////
  // Address decode
  ////////////////////

  // One access per request, only while ack is still low
  assign access   = reg_req_i && !ack_q;
  assign sel_boot = (reg_addr_i == board_pkg::AddrBootOvr);
  assign sel_fan  = (reg_addr_i == board_pkg::AddrFanOvr);

  always_comb begin
    rdata_d = board_pkg::RegErrValue;
    err_d   = 1'b1;
    case (reg_addr_i)
      board_pkg::AddrBootOvr: begin
        rdata_d = board_pkg::RegDataWidth'(boot_ovr_q);
        err_d   = 1'b0;
      end
      board_pkg::AddrFanOvr: begin
        rdata_d = board_pkg::RegDataWidth'(fan_ovr_q);
        err_d   = 1'b0;
      end
      // Writes here are dropped without an error
      board_pkg::AddrBoardId: begin
        rdata_d = board_pkg::BoardIdValue;
        err_d   = 1'b0;
      end
      default: ;
    endcase
  end

  ////////////////////
  // Handshake
  ////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else if (access) begin
      ack_q <= 1'b1;
      err_q <= err_d;
    end else if (!reg_req_i) begin
      ack_q <= 1'b0;
    end
  end

  // Response word stays put until the next access
  always_ff @(posedge soc_clk) begin
    if (access) begin
      rdata_q <= rdata_d;
    end
  end

  ////////////////////
  // Override regs
  ////////////////////

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_ovr_q <= '0;
      fan_ovr_q  <= '0;
    end else if (access && reg_we_i) begin
      if (sel_boot) begin
        boot_ovr_q <= reg_wdata_i[board_pkg::BootSelBit:0];
      end
      if (sel_fan) begin
        fan_ovr_q <= reg_wdata_i[board_pkg::FanEnBit:0];
      end
    end
  end

  assign reg_ack_o   = ack_q;
  assign reg_err_o   = err_q;
  assign reg_rdata_o = rdata_q;

  // Pins win unless software has taken over
  assign boot_mode_o = boot_ovr_q[board_pkg::BootSelBit] ?
                       boot_ovr_q[board_pkg::BootModeWidth-1:0] : boot_mode_i;
  assign fan_level_o = fan_ovr_q[board_pkg::FanEnBit] ?
                       fan_ovr_q[board_pkg::FanLevelWidth-1:0] : fan_sw_i;

endmodule

// File: hdl/fan_pwm.sv
/*
 * Fan PWM generator
 * Prescaled step counter compared against a fan level that is
 * latched once per PWM period
 */

`timescale 1ns/10ps

module fan_pwm (
  input  logic                                soc_clk,
  input  logic                                rst_n,
  input  logic [board_pkg::FanLevelWidth-1:0] fan_level_i,
  output logic                                fan_pwm_o
);

  logic [board_pkg::FanPrescWidth-1:0] presc_q;
  logic [board_pkg::FanStepWidth-1:0]  step_q;
  logic [board_pkg::FanLevelWidth-1:0] level_q;
  logic                                step_end;
  logic                                period_end;

  assign step_end   = (presc_q == board_pkg::FanPrescWidth'(board_pkg::FanStepCycles - 1));
  assign period_end = step_end &&
                      (step_q == board_pkg::FanStepWidth'(board_pkg::FanSteps - 1));

  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_q <= '0;
      step_q  <= '0;
      level_q <= '0;
    end else begin
      presc_q <= step_end ? '0 : presc_q + 1'b1;
      if (step_end) begin
        step_q <= period_end ? '0 : step_q + 1'b1;
      end
      // New level takes effect with the first step of the next period
      if (period_end) begin
        level_q <= fan_level_i;
      end
    end
  end

  // High for level steps out of FanSteps
  assign fan_pwm_o = (step_q < level_q);

endmodule

// File: hdl/rtc_divider.sv
/*
 * RTC divider
 * Toggles a registered tick every RtcHalfPeriod soc_clk cycles,
 * giving a 1 MHz RTC from the 50 MHz SoC clock
 */

`timescale 1ns/10ps

module rtc_divider (
  input  logic soc_clk,
  input  logic rst_n,
  output logic rtc_o
);

  logic [board_pkg::RtcCntWidth-1:0] cnt_q;
  logic                              tick_q;
  logic                              wrap;

  assign wrap = (cnt_q == board_pkg::RtcCntWidth'(board_pkg::RtcHalfPeriod - 1));

  // Counter restarts at zero on each half period
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q  <= '0;
      tick_q <= 1'b0;
    end else if (wrap) begin
      cnt_q  <= '0;
      tick_q <= ~tick_q;
    end else begin
      cnt_q  <= cnt_q + 1'b1;
    end
  end

  assign rtc_o = tick_q;

endmodule

// File: hdl/board_rst_sync.sv
/*
 * SoC reset synchronizer
 * Asserts asynchronously with rst_n and releases on soc_clk,
 * bypassed in test mode for scan
 */

`timescale 1ns/10ps

module board_rst_sync (
  input  logic soc_clk,
  input  logic rst_n,
  input  logic test_mode_i,
  output logic soc_rst_no
);

  logic [board_pkg::RstSyncStages-1:0] sync_q;

  ////////////////////
  // Release chain
  ////////////////////

  // Ones shift in from the bottom once rst_n is high
  always_ff @(posedge soc_clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[board_pkg::RstSyncStages-2:0], 1'b1};
    end
  end

  ////////////////////
  // Scan bypass
  ////////////////////

  // Test mode hands the raw board reset straight through
  assign soc_rst_no = test_mode_i ? rst_n : sync_q[board_pkg::RstSyncStages-1];

endmodule

// File: hdl/board_pkg.sv
/*
 * Board glue shared definitions
 * Register map, field positions, bus widths and timing constants
 * for the FPGA carrier support logic
 */

package board_pkg;

  ////////////////////
  // Bus widths
  ////////////////////

  localparam int unsigned RegAddrWidth  = 8;
  localparam int unsigned RegDataWidth  = 32;
  localparam int unsigned BootModeWidth = 2;
  localparam int unsigned FanLevelWidth = 4;

  ////////////////////
  // Register map
  ////////////////////

  localparam logic [RegAddrWidth-1:0] AddrBootOvr = 8'h00;
  localparam logic [RegAddrWidth-1:0] AddrFanOvr  = 8'h04;
  localparam logic [RegAddrWidth-1:0] AddrBoardId = 8'h08;

  localparam logic [RegDataWidth-1:0] BoardIdValue = 32'h0C4E_5A01;
  // Read data for any unmapped address
  localparam logic [RegDataWidth-1:0] RegErrValue  = 32'hBADC_AB1E;

  // Select and enable bits sit just above their fields
  localparam int unsigned BootSelBit = 2;
  localparam int unsigned FanEnBit   = 4;

  ////////////////////
  // Timing
  ////////////////////

  // 50 MHz soc_clk down to a 1 MHz RTC
  localparam int unsigned RtcHalfPeriod = 25;
  localparam int unsigned RtcCntWidth   = 16;

  localparam int unsigned FanStepCycles = 4;
  localparam int unsigned FanSteps      = 16;
  localparam int unsigned FanPrescWidth = $clog2(FanStepCycles);
  localparam int unsigned FanStepWidth  = $clog2(FanSteps);

  localparam int unsigned RstSyncStages = 2;

endpackage
